// File: design/coreMem_config.svh
//========================================
// Core memory block configuration
// Region bounds, RAM depths and control
// register offsets for one mesh tile
//========================================
`ifndef COREMEM_CONFIG_SVH
`define COREMEM_CONFIG_SVH

//========================================
// Region bounds on address bits 15..0
//========================================
`define IMEM_FLOOR 16'h0000
`define IMEM_ROOF  16'h0FFF
`define DMEM_FLOOR 16'h1000
`define DMEM_ROOF  16'h1FFF
`define CR_FLOOR   16'h2000
`define CR_ROOF    16'h20FF

// Depth in 32-bit words
`define IMEM_DEPTH 1024
`define DMEM_DEPTH 1024

//========================================
// Control register offsets
//========================================
`define CR_SCRATCH0 8'h00
`define CR_SCRATCH1 8'h04
`define CR_LED      8'h08
`define CR_SEG      8'h0C
`define CR_SW       8'h10
`define CR_KEY      8'h14

`endif

// File: design/coreMemPkg.sv
//========================================
// Core memory package
// Fabric transaction, address views and
// board pin types
//========================================
package coreMemPkg;

   typedef logic [7:0] tTileId;

   typedef enum logic [1:0] {
      WR     = 2'b00,
      RD     = 2'b01,
      RD_RSP = 2'b10
   } tFabricOp;

   // Local view, used for region decode and RAM index
   typedef struct packed {
      logic [15:0] upper;
      logic [15:0] offset;
   } tMemView;

   // Routing view, target tile in the top byte
   typedef struct packed {
      tTileId      target;
      logic [23:0] offset;
   } tRspView;

   typedef union packed {
      tMemView memView;
      tRspView rspView;
   } tFabricAddr;

   typedef struct packed {
      tFabricAddr  address;
      logic [31:0] data;
      tFabricOp    opcode;
      tTileId      requestorId;
      logic [1:0]  nextArbId;
   } tTileTrans;

   //========================================
   // Board pins
   //========================================
   typedef struct packed {
      logic [9:0] sw;
      logic [3:0] key;
   } tFpgaIn;

   typedef struct packed {
      logic [9:0]  led;
      logic [23:0] seg;
   } tFpgaOut;

endpackage

// File: design/instrMem.sv
//========================================
// Instruction memory
// Dual-port RAM, core fetch port and a
// fabric read/write port
//========================================
`include "coreMem_config.svh"

module instrMem (
   input  logic        Clk,
   // Core fetch
   input  logic [9:0]  pcWord,
   output logic [31:0] instruction,
   // Fabric side
   input  logic [9:0]  fabAddr,
   input  logic [31:0] fabData,
   input  logic        fabWrEn,
   output logic [31:0] fabRdData
);

   logic [31:0] mem [`IMEM_DEPTH];

   //========================================
   // Synchronous ports
   //========================================
   // Reads return the word stored before the edge
   always_ff @(posedge Clk) begin
      if (fabWrEn) begin
         mem[fabAddr] <= fabData;
      end
      fabRdData   <= mem[fabAddr];
      instruction <= mem[pcWord];
   end

endmodule

// File: design/dataMem.sv
//========================================
// Data memory
// Dual-port RAM, byte writes from the
// core and word writes from the fabric
//========================================
`include "coreMem_config.svh"

module dataMem (
   input  logic        Clk,
   // Core side
   input  logic [9:0]  coreAddr,
   input  logic [31:0] coreData,
   input  logic [3:0]  coreByteEn,
   input  logic        coreWrEn,
   output logic [31:0] coreRdData,
   // Fabric side
   input  logic [9:0]  fabAddr,
   input  logic [31:0] fabData,
   input  logic        fabWrEn,
   output logic [31:0] fabRdData
);

   logic [31:0] mem [`DMEM_DEPTH];

   //========================================
   // Write and read ports
   //========================================
   always_ff @(posedge Clk) begin
      // Full word from the fabric
      if (fabWrEn) begin
         mem[fabAddr] <= fabData;
      end
      // Only the enabled lanes from the core
      for (int lane = 0; lane < 4; lane++) begin
         if (coreWrEn && coreByteEn[lane]) begin
            mem[coreAddr][8*lane +: 8] <= coreData[8*lane +: 8];
         end
      end
      coreRdData <= mem[coreAddr];
      fabRdData  <= mem[fabAddr];
   end

endmodule

// File: design/ctrlRegMem.sv
//========================================
// Control register file
// Scratch, LED and segment registers plus
// sampled switches and keys, two ports
//========================================
`include "coreMem_config.svh"

module ctrlRegMem (
   input  logic                Clk,
   input  logic                rstN,
   // Core side
   input  logic [7:0]          coreOffset,
   input  logic [31:0]         coreData,
   input  logic                coreWrEn,
   input  logic                coreRdEn,
   output logic [31:0]         coreRdData,
   // Fabric side
   input  logic [7:0]          fabOffset,
   input  logic [31:0]         fabData,
   input  logic                fabWrEn,
   output logic [31:0]         fabRdData,
   // Board pins
   input  coreMemPkg::tFpgaIn  fpgaIn,
   output coreMemPkg::tFpgaOut fpgaOut
);
   import coreMemPkg::*;

   logic [31:0] scratch0;
   logic [31:0] scratch1;
   tFpgaIn      pinSample;

   // Word match, low two offset bits ignored
   function automatic logic isReg(input logic [7:0] offset, input logic [7:0] regOffset);
      return {offset[7:2], 2'b00} == regOffset;
   endfunction

   function automatic logic [31:0] readReg(input logic [7:0] offset);
      logic [31:0] value;
      case ({offset[7:2], 2'b00})
         `CR_SCRATCH0: value = scratch0;
         `CR_SCRATCH1: value = scratch1;
         `CR_LED:      value = {22'b0, fpgaOut.led};
         `CR_SEG:      value = {8'b0, fpgaOut.seg};
         `CR_SW:       value = {22'b0, pinSample.sw};
         `CR_KEY:      value = {28'b0, pinSample.key};
         default:      value = '0;
      endcase
      return value;
   endfunction

   //========================================
   // Register writes, core after fabric
   //========================================
   always_ff @(posedge Clk) begin
      if (fabWrEn && isReg(fabOffset, `CR_SCRATCH0)) scratch0 <= fabData;
      if (coreWrEn && isReg(coreOffset, `CR_SCRATCH0)) scratch0 <= coreData;
      if (fabWrEn && isReg(fabOffset, `CR_SCRATCH1)) scratch1 <= fabData;
      if (coreWrEn && isReg(coreOffset, `CR_SCRATCH1)) scratch1 <= coreData;
      pinSample <= fpgaIn;
   end

   // Board outputs
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         fpgaOut <= '0;
      end else begin
         if (fabWrEn && isReg(fabOffset, `CR_LED)) fpgaOut.led <= fabData[9:0];
         if (coreWrEn && isReg(coreOffset, `CR_LED)) fpgaOut.led <= coreData[9:0];
         if (fabWrEn && isReg(fabOffset, `CR_SEG)) fpgaOut.seg <= fabData[23:0];
         if (coreWrEn && isReg(coreOffset, `CR_SEG)) fpgaOut.seg <= coreData[23:0];
      end
   end

   //========================================
   // Registered reads
   //========================================
   always_ff @(posedge Clk) begin
      if (coreRdEn) begin
         coreRdData <= readReg(coreOffset);
      end
      fabRdData <= readReg(fabOffset);
   end

endmodule

// File: design/fabricResponder.sv
//========================================
// Fabric responder
// Region decode of fabric requests and a
// two-stage read response pipeline
//========================================
`include "coreMem_config.svh"

module fabricResponder (
   input  logic                  Clk,
   input  logic                  rstN,
   input  coreMemPkg::tTileId    localTileId,
   // Request, Q503
   input  logic                  inValid,
   input  coreMemPkg::tTileTrans inTrans,
   // Write strobes to the memories
   output logic                  iMemFabWrEn,
   output logic                  dMemFabWrEn,
   output logic                  crFabWrEn,
   // Port-b read data, Q504
   input  logic [31:0]           iMemRdData,
   input  logic [31:0]           dMemRdData,
   input  logic [31:0]           crRdData,
   // Response, Q505
   output logic                  outValid,
   output coreMemPkg::tTileTrans outTrans
);
   import coreMemPkg::*;

   logic [15:0] reqOffset;
   logic        iMemHitQ503H, dMemHitQ503H, crHitQ503H;
   logic        iMemHitQ504H, dMemHitQ504H, crHitQ504H;
   logic        isWrQ503H, isRdQ503H, rdValidQ504H;
   tTileTrans   rspHdrQ503H, rspHdrQ504H, rspQ504H;

   //========================================
   // Request decode, Q503
   //========================================
   assign reqOffset    = inTrans.address.memView.offset;
   assign iMemHitQ503H = (reqOffset >= `IMEM_FLOOR) && (reqOffset <= `IMEM_ROOF);
   assign dMemHitQ503H = (reqOffset >= `DMEM_FLOOR) && (reqOffset <= `DMEM_ROOF);
   assign crHitQ503H   = (reqOffset >= `CR_FLOOR) && (reqOffset <= `CR_ROOF);

   assign isWrQ503H   = inValid && (inTrans.opcode == WR);
   assign isRdQ503H   = inValid && (inTrans.opcode == RD);
   assign iMemFabWrEn = isWrQ503H && iMemHitQ503H;
   assign dMemFabWrEn = isWrQ503H && dMemHitQ503H;
   assign crFabWrEn   = isWrQ503H && crHitQ503H;

   // Response goes back to the requestor tile
   always_comb begin
      rspHdrQ503H                        = '0;
      rspHdrQ503H.address.rspView.target = inTrans.requestorId;
      rspHdrQ503H.address.rspView.offset = inTrans.address.rspView.offset;
      rspHdrQ503H.opcode                 = RD_RSP;
      rspHdrQ503H.requestorId            = localTileId;
      // nextArbId stays zero, the tile fills it in
   end

   //========================================
   // Stage Q504
   //========================================
   always_ff @(posedge Clk) begin
      iMemHitQ504H <= iMemHitQ503H;
      dMemHitQ504H <= dMemHitQ503H;
      crHitQ504H   <= crHitQ503H;
      rspHdrQ504H  <= rspHdrQ503H;
   end

   // CR has priority over IMEM, then DMEM
   always_comb begin
      rspQ504H      = rspHdrQ504H;
      rspQ504H.data = crHitQ504H   ? crRdData   :
                      iMemHitQ504H ? iMemRdData :
                      dMemHitQ504H ? dMemRdData :
                                     32'b0;
   end

   //========================================
   // Stage Q505
   //========================================
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         rdValidQ504H <= 1'b0;
         outValid     <= 1'b0;
      end else begin
         rdValidQ504H <= isRdQ503H;
         outValid     <= rdValidQ504H;
      end
   end

   always_ff @(posedge Clk) begin
      outTrans <= rspQ504H;
   end

endmodule

// File: design/coreMemWrap.sv
//========================================
// Core memory wrapper
// Instruction, data and control memories
// shared by the core and the mesh fabric
//========================================
`include "coreMem_config.svh"

module coreMemWrap (
   input  logic                  Clk,
   input  logic                  rstN,
   input  coreMemPkg::tTileId    localTileId,
   // Instruction fetch
   input  logic [31:0]           pcQ100H,
   output logic [31:0]           instructionQ101H,
   // Core data port
   input  logic [31:0]           dMemWrDataQ103H,
   input  logic [31:0]           dMemAddressQ103H,
   input  logic [3:0]            dMemByteEnQ103H,
   input  logic                  dMemWrEnQ103H,
   input  logic                  dMemRdEnQ103H,
   output logic [31:0]           dMemRdRspQ104H,
   // Fabric
   input  logic                  inFabricValidQ503H,
   input  coreMemPkg::tTileTrans inFabricQ503H,
   output logic                  outFabricValidQ505H,
   output coreMemPkg::tTileTrans outFabricQ505H,
   // Board pins
   input  coreMemPkg::tFpgaIn    fpgaIn,
   output coreMemPkg::tFpgaOut   fpgaOut
);
   import coreMemPkg::*;

   tFabricAddr  fabAddrQ503H;
   logic        iMemFabWrEn, dMemFabWrEn, crFabWrEn;
   logic [31:0] iMemFabRdData, dMemFabRdData, crFabRdData;
   logic        dMemHitQ103H, crHitQ103H;
   logic        dMemHitQ104H, crHitQ104H;
   logic [1:0]  byteOffsetQ104H;
   logic [31:0] shiftWrDataQ103H;
   logic [3:0]  shiftByteEnQ103H;
   logic [31:0] dMemRdDataQ104H, crRdDataQ104H, rawRdDataQ104H;

   assign fabAddrQ503H = inFabricQ503H.address;

   //========================================
   // Core region decode, Q103
   //========================================
   assign dMemHitQ103H = (dMemAddressQ103H[15:0] >= `DMEM_FLOOR) &&
                         (dMemAddressQ103H[15:0] <= `DMEM_ROOF);
   assign crHitQ103H   = (dMemAddressQ103H[15:0] >= `CR_FLOOR) &&
                         (dMemAddressQ103H[15:0] <= `CR_ROOF);

   // Move sub-word data onto its byte lanes
   assign shiftWrDataQ103H = dMemWrDataQ103H << {dMemAddressQ103H[1:0], 3'b000};
   assign shiftByteEnQ103H = dMemByteEnQ103H << dMemAddressQ103H[1:0];

   always_ff @(posedge Clk) begin
      dMemHitQ104H    <= dMemHitQ103H;
      crHitQ104H      <= crHitQ103H;
      byteOffsetQ104H <= dMemAddressQ103H[1:0];
   end

   //========================================
   // Read select and alignment, Q104
   //========================================
   assign rawRdDataQ104H = crHitQ104H   ? crRdDataQ104H   :
                           dMemHitQ104H ? dMemRdDataQ104H :
                                          32'b0;
   // Zero fill from the top
   assign dMemRdRspQ104H = rawRdDataQ104H >> {byteOffsetQ104H, 3'b000};

   //========================================
   // Memories
   //========================================
   instrMem iMem (
      .Clk         (Clk),
      .pcWord      (pcQ100H[11:2]),
      .instruction (instructionQ101H),
      .fabAddr     (fabAddrQ503H.memView.offset[11:2]),
      .fabData     (inFabricQ503H.data),
      .fabWrEn     (iMemFabWrEn),
      .fabRdData   (iMemFabRdData)
   );

   dataMem dMem (
      .Clk        (Clk),
      .coreAddr   (dMemAddressQ103H[11:2]),
      .coreData   (shiftWrDataQ103H),
      .coreByteEn (shiftByteEnQ103H),
      .coreWrEn   (dMemWrEnQ103H && dMemHitQ103H),
      .coreRdData (dMemRdDataQ104H),
      .fabAddr    (fabAddrQ503H.memView.offset[11:2]),
      .fabData    (inFabricQ503H.data),
      .fabWrEn    (dMemFabWrEn),
      .fabRdData  (dMemFabRdData)
   );

   // Registers are word wide, data goes in unshifted
   ctrlRegMem crMem (
      .Clk        (Clk),
      .rstN       (rstN),
      .coreOffset (dMemAddressQ103H[7:0]),
      .coreData   (dMemWrDataQ103H),
      .coreWrEn   (dMemWrEnQ103H && crHitQ103H),
      .coreRdEn   (dMemRdEnQ103H && crHitQ103H),
      .coreRdData (crRdDataQ104H),
      .fabOffset  (fabAddrQ503H.memView.offset[7:0]),
      .fabData    (inFabricQ503H.data),
      .fabWrEn    (crFabWrEn),
      .fabRdData  (crFabRdData),
      .fpgaIn     (fpgaIn),
      .fpgaOut    (fpgaOut)
   );

   //========================================
   // Fabric requests and responses
   //========================================
   fabricResponder fabResp (
      .Clk         (Clk),
      .rstN        (rstN),
      .localTileId (localTileId),
      .inValid     (inFabricValidQ503H),
      .inTrans     (inFabricQ503H),
      .iMemFabWrEn (iMemFabWrEn),
      .dMemFabWrEn (dMemFabWrEn),
      .crFabWrEn   (crFabWrEn),
      .iMemRdData  (iMemFabRdData),
      .dMemRdData  (dMemFabRdData),
      .crRdData    (crFabRdData),
      .outValid    (outFabricValidQ505H),
      .outTrans    (outFabricQ505H)
   );

endmodule

// File: bench/coreMemWrap_chk.sv
//========================================
// Fabric response checker
// Concurrent assertions on the response
// valid and opcode, bound to the wrapper
//========================================
module coreMemWrap_chk (
   input logic                  Clk,
   input logic                  rstN,
   input logic                  inFabricValidQ503H,
   input coreMemPkg::tTileTrans inFabricQ503H,
   input logic                  outFabricValidQ505H,
   input coreMemPkg::tTileTrans outFabricQ505H
);
   timeunit 1ns;
   timeprecision 100ps;

   import coreMemPkg::*;

   logic rdStrobe;
   int   failCount = 0;

   assign rdStrobe = inFabricValidQ503H && (inFabricQ503H.opcode == RD);

   // Low on the first edge out of reset
   assert property (@(posedge Clk) $rose(rstN) |-> !outFabricValidQ505H)
      else begin
         failCount++;
         $error("Response valid high coming out of reset");
      end

   // Every read gets its response two cycles later
   assert property (@(posedge Clk) disable iff (!rstN) rdStrobe |-> ##2 outFabricValidQ505H)
      else begin
         failCount++;
         $error("Read request without a response two cycles later");
      end

   // And no response comes without a read
   assert property (@(posedge Clk) disable iff (!rstN)
                    outFabricValidQ505H |-> $past(rdStrobe, 2))
      else begin
         failCount++;
         $error("Response valid without a read two cycles earlier");
      end

   assert property (@(posedge Clk) disable iff (!rstN)
                    outFabricValidQ505H |-> outFabricQ505H.opcode == RD_RSP)
      else begin
         failCount++;
         $error("Response carries an opcode other than RD_RSP");
      end

endmodule

bind coreMemWrap coreMemWrap_chk chk0 (.*);

// File: bench/coreMemWrapTb.sv
//========================================
// Core memory wrapper testbench
// Table of core and fabric operations
// checked against a reference model
//========================================
`include "coreMem_config.svh"

module coreMemWrapTb;
   timeunit 1ns;
   timeprecision 100ps;

   import coreMemPkg::*;

   typedef enum logic [2:0] {FETCH, CORE_WR, CORE_RD, FAB_WR, FAB_RD, SET_PINS} tStepKind;

   // FAB_RD steps carry the requestor in data[7:0]
   typedef struct packed {
      tStepKind    kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  byteEn;
      logic [31:0] expValue;
      tFpgaOut     expPins;
   } tStep;

   localparam tTileId LOCAL_TILE = 8'h3C;

   logic        Clk, rstN;
   tTileId      localTileId;
   logic [31:0] pcQ100H, instructionQ101H;
   logic [31:0] dMemWrDataQ103H, dMemAddressQ103H, dMemRdRspQ104H;
   logic [3:0]  dMemByteEnQ103H;
   logic        dMemWrEnQ103H, dMemRdEnQ103H;
   logic        inFabricValidQ503H, outFabricValidQ505H;
   tTileTrans   inFabricQ503H, outFabricQ505H;
   tFpgaIn      fpgaIn;
   tFpgaOut     fpgaOut;

   tStep        steps[$];
   tTileTrans   rspQueue[$];
   int          dueQueue[$];
   int          cycleCount = 0;
   int          cycleLimit = 0;
   int          checkCount = 0;
   int          errorCount = 0;
   int          otherErrors = 0;
   logic [31:0] lcgState = 32'he251;

   // Reference model state
   logic [31:0] imemModel [int];
   logic [31:0] dmemModel [int];
   logic [31:0] scratch0, scratch1;
   logic [9:0]  ledModel, swModel;
   logic [23:0] segModel;
   logic [3:0]  keyModel;

   coreMemWrap dut0 (.*);

   initial begin
      Clk = 1'b0;
      forever #10 Clk = ~Clk;
   end

   always @(posedge Clk) cycleCount <= cycleCount + 1;

   initial begin
      wait (cycleLimit > 0);
      wait (cycleCount >= cycleLimit);
      $display("Error: run did not finish within %0d cycles", cycleLimit);
      $display(">>> FAIL");
      $finish;
   end

   //========================================
   // Helpers
   //========================================
   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Random upper half exercises the routing bits 23..16
   function automatic logic [31:0] randomUpper(input logic [15:0] offset);
      logic [31:0] rnd;
      rnd = nextRand();
      return {rnd[31:16], offset};
   endfunction

   function automatic logic imemHit(input logic [31:0] addr);
      return addr[15:0] <= `IMEM_ROOF;
   endfunction

   function automatic logic dmemHit(input logic [31:0] addr);
      return (addr[15:0] >= `DMEM_FLOOR) && (addr[15:0] <= `DMEM_ROOF);
   endfunction

   function automatic logic crHit(input logic [31:0] addr);
      return (addr[15:0] >= `CR_FLOOR) && (addr[15:0] <= `CR_ROOF);
   endfunction

   function automatic logic [31:0] regValue(input logic [7:0] offset);
      case ({offset[7:2], 2'b00})
         `CR_SCRATCH0: return scratch0;
         `CR_SCRATCH1: return scratch1;
         `CR_LED:      return {22'b0, ledModel};
         `CR_SEG:      return {8'b0, segModel};
         `CR_SW:       return {22'b0, swModel};
         `CR_KEY:      return {28'b0, keyModel};
         default:      return 32'b0;
      endcase
   endfunction

   task automatic storeReg(input logic [7:0] offset, input logic [31:0] data);
      case ({offset[7:2], 2'b00})
         `CR_SCRATCH0: scratch0 = data;
         `CR_SCRATCH1: scratch1 = data;
         `CR_LED:      ledModel = data[9:0];
         `CR_SEG:      segModel = data[23:0];
         default:      ;
      endcase
   endtask

   // Model one operation and append it with its expected values
   task automatic addStep(input tStepKind kind, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] byteEn);
      tStep        s;
      int          idx;
      logic [31:0] word, shData;
      logic [3:0]  shBe;
      idx = addr[11:2];
      s = '0;
      s.kind = kind;
      s.addr = addr;
      s.data = data;
      s.byteEn = byteEn;
      case (kind)
         FETCH:   s.expValue = imemModel[idx];
         CORE_WR: begin
            if (crHit(addr)) begin
               storeReg(addr[7:0], data);
            end else if (dmemHit(addr)) begin
               shData = data << (8 * addr[1:0]);
               shBe = byteEn << addr[1:0];
               word = dmemModel.exists(idx) ? dmemModel[idx] : 32'bx;
               for (int lane = 0; lane < 4; lane++) begin
                  if (shBe[lane]) word[8*lane +: 8] = shData[8*lane +: 8];
               end
               dmemModel[idx] = word;
            end
         end
         CORE_RD: begin
            if (crHit(addr)) s.expValue = regValue(addr[7:0]) >> (8 * addr[1:0]);
            else if (dmemHit(addr)) s.expValue = dmemModel[idx] >> (8 * addr[1:0]);
         end
         FAB_WR: begin
            if (crHit(addr)) storeReg(addr[7:0], data);
            else if (imemHit(addr)) imemModel[idx] = data;
            else if (dmemHit(addr)) dmemModel[idx] = data;
         end
         FAB_RD: begin
            if (crHit(addr)) s.expValue = regValue(addr[7:0]);
            else if (imemHit(addr)) s.expValue = imemModel[idx];
            else if (dmemHit(addr)) s.expValue = dmemModel[idx];
         end
         SET_PINS: begin
            swModel = data[13:4];
            keyModel = data[3:0];
         end
         default: ;
      endcase
      s.expPins.led = ledModel;
      s.expPins.seg = segModel;
      steps.push_back(s);
   endtask

   task automatic checkEqual(input logic [79:0] got, input logic [79:0] expected,
                             input string what);
      checkCount++;
      if (got !== expected) begin
         errorCount++;
         $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      end
   endtask

   function automatic tTileTrans makeRequest(input tFabricOp op, input tStep s);
      tTileTrans t;
      t = '0;
      t.address = s.addr;
      t.opcode = op;
      t.data = (op == WR) ? s.data : 32'b0;
      t.requestorId = (op == RD) ? s.data[7:0] : 8'h01;
      return t;
   endfunction

   // Expected response goes back to the requestor with the low 24 address bits
   function automatic tTileTrans expectedResponse(input tStep s);
      tTileTrans t;
      t = '0;
      t.address.rspView.target = s.data[7:0];
      t.address.rspView.offset = s.addr[23:0];
      t.data = s.expValue;
      t.opcode = RD_RSP;
      t.requestorId = LOCAL_TILE;
      return t;
   endfunction

   task automatic clearStrobes();
      dMemWrEnQ103H = 1'b0;
      dMemRdEnQ103H = 1'b0;
      inFabricValidQ503H = 1'b0;
   endtask

   task automatic driveStep(input tStep s);
      clearStrobes();
      case (s.kind)
         FETCH:   pcQ100H = s.addr;
         CORE_WR, CORE_RD: begin
            dMemAddressQ103H = s.addr;
            dMemWrDataQ103H = s.data;
            dMemByteEnQ103H = s.byteEn;
            dMemWrEnQ103H = (s.kind == CORE_WR);
            dMemRdEnQ103H = (s.kind == CORE_RD);
         end
         FAB_WR: begin
            inFabricQ503H = makeRequest(WR, s);
            inFabricValidQ503H = 1'b1;
         end
         FAB_RD: begin
            inFabricQ503H = makeRequest(RD, s);
            inFabricValidQ503H = 1'b1;
            rspQueue.push_back(expectedResponse(s));
            dueQueue.push_back(cycleCount + 2);
         end
         SET_PINS: fpgaIn = s.data[13:0];
         default: ;
      endcase
   endtask

   task automatic checkStep(input tStep s, input int i);
      if (s.kind == FETCH) begin
         checkEqual(instructionQ101H, s.expValue, $sformatf("step %0d fetch %h", i, s.addr));
      end else if (s.kind == CORE_RD) begin
         checkEqual(dMemRdRspQ104H, s.expValue, $sformatf("step %0d core read %h", i, s.addr));
      end
      checkEqual(fpgaOut, s.expPins, $sformatf("step %0d board outputs", i));
   endtask

   //========================================
   // Fabric response monitor
   //========================================
   always begin : respMonitor
      tTileTrans expRsp;
      int        due;
      @(posedge Clk);
      #1;
      if (outFabricValidQ505H === 1'b1) begin
         if (rspQueue.size() == 0) begin
            otherErrors++;
            $display("Error: fabric response at %0t ns with no read outstanding", $time);
         end else begin
            expRsp = rspQueue.pop_front();
            due = dueQueue.pop_front();
            checkEqual(cycleCount, due, "fabric response cycle");
            checkEqual(outFabricQ505H, expRsp, "fabric response");
         end
      end
   end

   //========================================
   // Table and main sequence
   //========================================
   initial begin
      rstN = 1'b0;
      localTileId = LOCAL_TILE;
      pcQ100H = '0;
      dMemAddressQ103H = '0;
      dMemWrDataQ103H = '0;
      dMemByteEnQ103H = '0;
      inFabricQ503H = '0;
      fpgaIn = '0;
      clearStrobes();
      {ledModel, segModel, swModel, keyModel} = '0;

      // Fabric loads instructions, core fetches them
      addStep(FAB_WR, randomUpper(16'h0040), nextRand(), 4'hF);
      addStep(FAB_WR, randomUpper(16'h0FFC), nextRand(), 4'hF);
      addStep(FETCH, 32'h0000_0040, 0, 0);
      addStep(FETCH, 32'h0000_0FFC, 0, 0);
      // Sub-word writes and reads
      addStep(CORE_WR, 32'h0000_1100, nextRand(), 4'hF);
      addStep(CORE_WR, 32'h0000_1101, nextRand(), 4'b0001);
      addStep(CORE_RD, 32'h0000_1101, 0, 0);
      addStep(CORE_WR, 32'h0000_1102, nextRand(), 4'b0011);
      addStep(CORE_RD, 32'h0000_1102, 0, 0);
      addStep(CORE_WR, 32'h0000_1103, nextRand(), 4'b0001);
      addStep(CORE_RD, 32'h0000_1103, 0, 0);
      addStep(CORE_WR, 32'h0000_1104, nextRand(), 4'hF);
      addStep(CORE_WR, 32'h0000_1107, nextRand(), 4'b0011);
      addStep(CORE_RD, 32'h0000_1107, 0, 0);
      addStep(CORE_RD, 32'h0000_1104, 0, 0);
      addStep(CORE_RD, 32'h0000_1100, 0, 0);
      // Control registers and pins
      addStep(CORE_WR, 32'h0000_2000, nextRand(), 4'hF);
      addStep(CORE_WR, 32'h0000_2004, nextRand(), 4'hF);
      addStep(CORE_WR, 32'h0000_2008, nextRand(), 4'hF);
      addStep(CORE_WR, 32'h0000_200C, nextRand(), 4'hF);
      addStep(SET_PINS, 0, nextRand(), 0);
      for (int off = 'h00; off <= 'h20; off += 4) addStep(CORE_RD, 32'h2000 + off, 0, 0);
      addStep(CORE_RD, 32'h0000_3000, 0, 0);
      addStep(CORE_RD, 32'h0000_0040, 0, 0);
      // Fabric reads of every region, back to back
      addStep(FAB_RD, randomUpper(16'h1100), nextRand(), 0);
      addStep(FAB_RD, randomUpper(16'h0040), nextRand(), 0);
      addStep(FAB_RD, randomUpper(16'h2008), nextRand(), 0);
      addStep(FAB_RD, randomUpper(16'h2010), nextRand(), 0);
      addStep(FAB_RD, randomUpper(16'h3000), nextRand(), 0);
      // Core and fabric sharing the data region
      addStep(CORE_WR, 32'h0000_1200, nextRand(), 4'hF);
      addStep(FAB_RD, randomUpper(16'h1200), nextRand(), 0);
      addStep(FAB_WR, randomUpper(16'h1204), nextRand(), 4'hF);
      addStep(CORE_RD, 32'h0000_1204, 0, 0);
      addStep(FAB_WR, randomUpper(16'h2004), nextRand(), 4'hF);
      addStep(CORE_RD, 32'h0000_2004, 0, 0);
      addStep(FAB_WR, randomUpper(16'h2008), nextRand(), 4'hF);
      addStep(FAB_WR, randomUpper(16'h200C), nextRand(), 4'hF);
      addStep(FAB_RD, randomUpper(16'h200C), nextRand(), 0);
      cycleLimit = 4 * steps.size() + 20;

      repeat (2) @(posedge Clk);
      #2;
      rstN = 1'b1;
      checkEqual(outFabricValidQ505H, 1'b0, "response valid after reset");
      checkEqual(fpgaOut, '0, "board outputs after reset");

      foreach (steps[i]) begin
         driveStep(steps[i]);
         @(posedge Clk);
         #1;
         checkStep(steps[i], i);
         #1;
      end
      clearStrobes();
      repeat (3) @(posedge Clk);
      #2;

      if (rspQueue.size() != 0) begin
         otherErrors += rspQueue.size();
         $display("Error: %0d fabric responses never arrived", rspQueue.size());
      end
      $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
               checkCount, errorCount, otherErrors, dut0.chk0.failCount);
      if (errorCount == 0 && otherErrors == 0 && dut0.chk0.failCount == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: coreMemWrap.f
+incdir+design
design/coreMemPkg.sv
design/instrMem.sv
design/dataMem.sv
design/ctrlRegMem.sv
design/fabricResponder.sv
design/coreMemWrap.sv
bench/coreMemWrap_chk.sv
bench/coreMemWrapTb.sv
